//--- Bender.yml
package:
  name: tcm_subsys

sources:
  - hw/tcm_pkg.sv
  - hw/ram_sp.sv
  - hw/dtcm.sv
  - hw/tcm_arbiter.sv
  - hw/axil_tcm_bridge.sv
  - hw/tcm_subsys.sv
  - target: dv
    files:
      - dv/tcm_subsys_asserts.sv
      - dv/tb_tcm_subsys.sv

//--- dv/tb_tcm_subsys.sv
// Testbench for tcm_subsys with LCG stimulus, byte-array model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_tcm_subsys
  import tcm_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  localparam logic [31:0] SEED = 32'hd567d53a;
  localparam int WIN_BASE  = 32'h0000_c000;
  localparam int WIN_WORDS = 512;
  localparam int N_LSU     = 200;
  localparam int N_AXI     = 100;
  localparam int N_CROSS   = 8;
  localparam int N_OOB     = 4;
  localparam int N_MIX_LSU = 200;
  localparam int N_MIX_AXI = 100;
  localparam int TOTAL_OPS = WIN_WORDS + N_LSU + N_AXI + 6 * N_CROSS + 5 * N_OOB
                             + N_MIX_LSU + N_MIX_AXI;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 20 + RESET_CYCLES;

  typedef struct packed {
    logic        rd;
    logic        err;
    logic [63:0] data;
    logic [31:0] cyc;
  } lsu_exp_t;

  logic clk;
  logic rstn;
  logic lsu_cmd_valid, lsu_cmd_ready, lsu_cmd_read, lsu_rsp_valid, lsu_rsp_ready, lsu_rsp_err;
  logic [31:0] lsu_cmd_addr;
  logic [63:0] lsu_cmd_wdata, lsu_rsp_rdata;
  logic [7:0]  lsu_cmd_wmask;
  logic [31:0] s_axi_awaddr, s_axi_wdata, s_axi_araddr, s_axi_rdata;
  logic [3:0]  s_axi_wstrb;
  logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready, s_axi_bvalid, s_axi_bready;
  logic s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;
  axi_resp_t s_axi_bresp, s_axi_rresp;

  logic [7:0]  model [TCM_BYTES];
  lsu_exp_t    exp_q [$];
  logic [31:0] lsu_rng, axi_rng, rdy_rng;
  logic        lsu_bp, axi_bp, strict_lat;
  int          cyc = 0;
  int          chk_cnt = 0;
  int          err_cnt = 0;

  tcm_subsys i_tcm_subsys (
    .clk (clk), .rstn (rstn),
    .lsu_cmd_valid (lsu_cmd_valid), .lsu_cmd_ready (lsu_cmd_ready),
    .lsu_cmd_addr (lsu_cmd_addr), .lsu_cmd_read (lsu_cmd_read),
    .lsu_cmd_wdata (lsu_cmd_wdata), .lsu_cmd_wmask (lsu_cmd_wmask),
    .lsu_rsp_valid (lsu_rsp_valid), .lsu_rsp_ready (lsu_rsp_ready),
    .lsu_rsp_rdata (lsu_rsp_rdata), .lsu_rsp_err (lsu_rsp_err),
    .s_axi_awaddr (s_axi_awaddr), .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready), .s_axi_wdata (s_axi_wdata),
    .s_axi_wstrb (s_axi_wstrb), .s_axi_wvalid (s_axi_wvalid),
    .s_axi_wready (s_axi_wready), .s_axi_bresp (s_axi_bresp),
    .s_axi_bvalid (s_axi_bvalid), .s_axi_bready (s_axi_bready),
    .s_axi_araddr (s_axi_araddr), .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready), .s_axi_rdata (s_axi_rdata),
    .s_axi_rresp (s_axi_rresp), .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rready (s_axi_rready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lcg(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic next_axi_ready();
    axi_rng = lcg(axi_rng);
    return !axi_bp || axi_rng[31] || axi_rng[30];
  endfunction

  function automatic logic in_range(input logic [31:0] addr);
    return addr < TCM_BYTES;
  endfunction

  // Little endian with byte i of the value at base + i
  function automatic logic [63:0] model_bytes(input logic [31:0] base, input int n);
    logic [63:0] v;
    v = '0;
    if (in_range(base)) begin
      for (int i = 0; i < n; i++) v[8*i +: 8] = model[base + i];
    end
    return v;
  endfunction

  task automatic model_store(input logic [31:0] base, input logic [63:0] data,
                             input logic [7:0] mask);
    for (int i = 0; i < 8; i++) begin
      if (mask[i] && in_range(base)) model[base + i] = data[8*i +: 8];
    end
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    chk_cnt++;
    assert (cond) else begin
      err_cnt++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  task automatic end_run();
    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  // ----------------------------------------------------------------------
  // LSU port
  // ----------------------------------------------------------------------
  // Called and returns 1 ns after a rising edge
  task automatic lsu_op(input logic rd, input logic [31:0] addr,
                        input logic [63:0] wdata, input logic [7:0] mask);
    lsu_exp_t ent;
    lsu_cmd_addr  = addr;
    lsu_cmd_read  = rd;
    lsu_cmd_wdata = wdata;
    lsu_cmd_wmask = mask;
    lsu_cmd_valid = 1'b1;
    @(negedge clk);
    while (!lsu_cmd_ready) @(negedge clk);
    ent.rd   = rd;
    ent.err  = !in_range(addr);
    ent.data = rd ? model_bytes({addr[31:3], 3'b000}, 8) : '0;
    ent.cyc  = cyc;
    if (!rd) begin
      model_store({addr[31:3], 3'b000}, wdata, mask);
    end
    exp_q.push_back(ent);
    @(posedge clk);
    #1;
    lsu_cmd_valid = 1'b0;
  endtask

  task automatic lsu_drain();
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic lsu_random(input int n, input int lo, input int nwords);
    logic [31:0] addr;
    logic [31:0] r;
    for (int k = 0; k < n; k++) begin
      lsu_rng = lcg(lsu_rng);
      r = lsu_rng;
      addr = WIN_BASE + 8 * (lo + (r >> 16) % nwords);
      lsu_rng = lcg(lsu_rng);
      lsu_op(r[31], addr, {lsu_rng, ~r}, lsu_rng[31:24]);
      // Occasional idle cycle between commands
      if (r[30:29] == 2'b00) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  // Response checker that also drives lsu_rsp_ready
  initial begin : lsu_monitor
    lsu_exp_t ent;
    lsu_rsp_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      rdy_rng = lcg(rdy_rng);
      lsu_rsp_ready = !lsu_bp || rdy_rng[31] || rdy_rng[30];
      @(negedge clk);
      if (lsu_rsp_valid && lsu_rsp_ready) begin
        if (exp_q.size() == 0) begin
          check_true(1'b0, "LSU response arrived with no command outstanding");
        end else begin
          ent = exp_q.pop_front();
          check_val("lsu_rsp_err", lsu_rsp_err, ent.err);
          if (ent.rd) begin
            check_val("lsu_rsp_rdata", lsu_rsp_rdata, ent.data);
          end
          if (strict_lat) begin
            check_true(cyc == ent.cyc + 1, "LSU response not one cycle after acceptance");
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // AXI4-Lite port
  // ----------------------------------------------------------------------
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic done;
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    @(negedge clk);
    while (!s_axi_awready) @(negedge clk);
    check_true(s_axi_wready, "wready not raised together with awready");
    model_store({addr[31:2], 2'b00}, {32'b0, data}, {4'b0, strb});
    @(posedge clk);
    #1;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    done = 1'b0;
    while (!done) begin
      s_axi_bready = next_axi_ready();
      @(negedge clk);
      done = s_axi_bvalid && s_axi_bready;
      if (done) begin
        check_val("s_axi_bresp", s_axi_bresp, in_range(addr) ? OKAY : SLVERR);
      end
      @(posedge clk);
      #1;
    end
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr);
    logic done;
    int   ar_cyc;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    @(negedge clk);
    while (!s_axi_arready) @(negedge clk);
    ar_cyc = cyc;
    @(posedge clk);
    #1;
    s_axi_arvalid = 1'b0;
    done = 1'b0;
    while (!done) begin
      s_axi_rready = next_axi_ready();
      @(negedge clk);
      done = s_axi_rvalid && s_axi_rready;
      if (done) begin
        check_val("s_axi_rresp", s_axi_rresp, in_range(addr) ? OKAY : SLVERR);
        check_val("s_axi_rdata", s_axi_rdata, model_bytes({addr[31:2], 2'b00}, 4));
        check_true(cyc - ar_cyc >= 3, "AXI read returned in fewer than three cycles");
      end
      @(posedge clk);
      #1;
    end
    s_axi_rready = 1'b0;
  endtask

  task automatic axi_random(input int n, input int lo, input int nwords);
    logic [31:0] addr;
    logic [31:0] r;
    for (int k = 0; k < n; k++) begin
      axi_rng = lcg(axi_rng);
      r = axi_rng;
      addr = WIN_BASE + 8 * (lo + (r >> 16) % nwords) + (r[31] ? 4 : 0);
      axi_rng = lcg(axi_rng);
      if (r[30]) begin
        axi_read(addr);
      end else begin
        axi_write(addr, axi_rng, axi_rng[31:28]);
      end
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    check_true(1'b0, "watchdog expired before the traffic completed");
    end_run();
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin : main
    logic [31:0] addr;
    logic [31:0] oob;
    rstn = 1'b0;
    {lsu_cmd_valid, lsu_cmd_read, lsu_cmd_addr, lsu_cmd_wdata, lsu_cmd_wmask} = '0;
    {s_axi_awvalid, s_axi_wvalid, s_axi_bready, s_axi_arvalid, s_axi_rready} = '0;
    {s_axi_awaddr, s_axi_wdata, s_axi_wstrb, s_axi_araddr} = '0;
    lsu_rng = SEED;
    axi_rng = ~SEED;
    rdy_rng = SEED ^ 32'h0f0f_0f0f;
    {lsu_bp, axi_bp, strict_lat} = 3'b001;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(negedge clk);
    check_val("lsu_rsp_valid", lsu_rsp_valid, 1'b0);
    check_val("s_axi_rvalid", s_axi_rvalid, 1'b0);
    check_val("s_axi_bvalid", s_axi_bvalid, 1'b0);
    @(posedge clk);
    #1;
    // Fill the window with a pattern built from the whole address
    for (int i = 0; i < WIN_WORDS; i++) begin
      addr = WIN_BASE + 8 * i;
      lsu_op(1'b0, addr, {addr ^ 32'h5a5a_c3c3, ~addr}, 8'hff);
    end
    lsu_random(N_LSU, 0, WIN_WORDS);
    lsu_drain();
    axi_random(N_AXI, 0, WIN_WORDS);
    // Cross-port traffic in both directions
    for (int k = 0; k < N_CROSS; k++) begin
      lsu_rng = lcg(lsu_rng);
      addr = WIN_BASE + 8 * ((lsu_rng >> 16) % WIN_WORDS);
      lsu_op(1'b0, addr, {lsu_rng, lcg(lsu_rng)}, 8'hff);
      lsu_drain();
      axi_read(addr);
      axi_read(addr + 4);
      axi_write(addr, ~lsu_rng, 4'hf);
      axi_write(addr + 4, lsu_rng ^ 32'h1234_5678, 4'hf);
      lsu_op(1'b1, addr, '0, '0);
      lsu_drain();
    end
    // Out-of-range accesses leave the aliased word unchanged
    for (int k = 0; k < N_OOB; k++) begin
      lsu_rng = lcg(lsu_rng);
      addr = WIN_BASE + 8 * ((lsu_rng >> 16) % WIN_WORDS);
      oob  = addr | (32'h1 << (16 + lsu_rng[31:28]));
      lsu_op(1'b0, oob, {lsu_rng, ~lsu_rng}, 8'hff);
      lsu_op(1'b1, oob, '0, '0);
      lsu_drain();
      axi_write(oob + 4, lsu_rng, 4'hf);
      axi_read(oob);
      lsu_op(1'b1, addr, '0, '0);
      lsu_drain();
    end
    // Both ports at once with back-pressure on disjoint halves of the window
    {lsu_bp, axi_bp, strict_lat} = 3'b110;
    fork
      lsu_random(N_MIX_LSU, 0, WIN_WORDS / 2);
      axi_random(N_MIX_AXI, WIN_WORDS / 2, WIN_WORDS / 2);
    join
    lsu_drain();
    // No stray LSU response once every command has been answered
    @(negedge clk);
    check_val("lsu_rsp_valid", lsu_rsp_valid, 1'b0);
    end_run();
  end

endmodule

`default_nettype wire

//--- dv/tcm_subsys_asserts.sv
// Concurrent handshake assertions for the TCM subsystem ports, with bind
`timescale 1ns/1ps
`default_nettype none

module tcm_subsys_asserts (
  input wire logic        clk,
  input wire logic        rstn,
  input wire logic        lsu_cmd_valid,
  input wire logic        lsu_cmd_ready,
  input wire logic        lsu_rsp_valid,
  input wire logic        lsu_rsp_ready,
  input wire logic [63:0] lsu_rsp_rdata,
  input wire logic        lsu_rsp_err,
  input wire logic        s_axi_rvalid,
  input wire logic        s_axi_rready,
  input wire logic        s_axi_bvalid,
  input wire logic        s_axi_bready
);

  // ----------------------------------------------------------------------
  // LSU response port
  // ----------------------------------------------------------------------
  // Stalled response keeps valid, data and error
  lsu_rsp_hold: assert property (@(posedge clk) disable iff (!rstn)
    lsu_rsp_valid && !lsu_rsp_ready |=>
      lsu_rsp_valid && $stable(lsu_rsp_rdata) && $stable(lsu_rsp_err))
    else $error("LSU response dropped or changed while stalled");

  // Registered response right after acceptance
  lsu_rsp_follows: assert property (@(posedge clk) disable iff (!rstn)
    lsu_cmd_valid && lsu_cmd_ready |=> lsu_rsp_valid)
    else $error("no LSU response after an accepted command");

  // ----------------------------------------------------------------------
  // AXI4-Lite response channels
  // ----------------------------------------------------------------------
  rvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
    else $error("rvalid dropped before rready");

  bvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else $error("bvalid dropped before bready");

  rsp_low_in_reset: assert property (@(posedge clk)
    !rstn |-> !s_axi_rvalid && !s_axi_bvalid)
    else $error("AXI response valid high during reset");

endmodule

bind tcm_subsys tcm_subsys_asserts i_tcm_subsys_asserts (
  .clk           (clk),
  .rstn          (rstn),
  .lsu_cmd_valid (lsu_cmd_valid),
  .lsu_cmd_ready (lsu_cmd_ready),
  .lsu_rsp_valid (lsu_rsp_valid),
  .lsu_rsp_ready (lsu_rsp_ready),
  .lsu_rsp_rdata (lsu_rsp_rdata),
  .lsu_rsp_err   (lsu_rsp_err),
  .s_axi_rvalid  (s_axi_rvalid),
  .s_axi_rready  (s_axi_rready),
  .s_axi_bvalid  (s_axi_bvalid),
  .s_axi_bready  (s_axi_bready)
);

`default_nettype wire

//--- hw/axil_tcm_bridge.sv
// AXI4-Lite slave turning 32-bit transfers into 64-bit DTCM commands
`timescale 1ns/1ps
`default_nettype none

module axil_tcm_bridge
  import tcm_pkg::*;
(
  input  logic                    clk,
  input  logic                    rstn,
  // AXI4-Lite slave
  input  logic [ADDR_W-1:0]       s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  logic [AXI_DATA_W-1:0]   s_axi_wdata,
  input  logic [AXI_DATA_W/8-1:0] s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output axi_resp_t               s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  input  logic [ADDR_W-1:0]       s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output logic [AXI_DATA_W-1:0]   s_axi_rdata,
  output axi_resp_t               s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready,
  // DTCM command master
  output logic                    tcm_cmd_valid,
  input  logic                    tcm_cmd_ready,
  output logic [ADDR_W-1:0]       tcm_cmd_addr,
  output logic                    tcm_cmd_read,
  output logic [DATA_W-1:0]       tcm_cmd_wdata,
  output logic [STRB_W-1:0]       tcm_cmd_wmask,
  input  logic                    tcm_rsp_valid,
  output logic                    tcm_rsp_ready,
  input  logic [DATA_W-1:0]       tcm_rsp_rdata,
  input  logic                    tcm_rsp_err
);

  bridge_state_t state_q;
  bridge_state_t state_d;

  logic                    wr_q;
  logic [ADDR_W-1:0]       addr_q;
  logic [AXI_DATA_W-1:0]   wdata_q;
  logic [AXI_DATA_W/8-1:0] wstrb_q;
  logic [AXI_DATA_W-1:0]   rdata_q;
  axi_resp_t               resp_q;
  logic                    hi_sel;

  // Upper 32-bit half of the DTCM word
  assign hi_sel = addr_q[2];

  // ----------------------------------------------------------------------
  // AXI handshakes
  // ----------------------------------------------------------------------
  // Reads take priority, AW and W are only taken together
  assign s_axi_arready = (state_q == IDLE) && s_axi_arvalid;
  assign s_axi_awready = (state_q == IDLE) && !s_axi_arvalid
                         && s_axi_awvalid && s_axi_wvalid;
  assign s_axi_wready  = s_axi_awready;

  assign s_axi_rvalid  = (state_q == SEND) && !wr_q;
  assign s_axi_bvalid  = (state_q == SEND) && wr_q;
  assign s_axi_rdata   = rdata_q;
  assign s_axi_rresp   = resp_q;
  assign s_axi_bresp   = resp_q;

  // ----------------------------------------------------------------------
  // DTCM command
  // ----------------------------------------------------------------------
  assign tcm_cmd_valid = (state_q == RD_CMD) || (state_q == WR_CMD);
  assign tcm_cmd_addr  = addr_q;
  assign tcm_cmd_read  = (state_q == RD_CMD);
  // Same data in both halves, the mask picks the half
  assign tcm_cmd_wdata = {wdata_q, wdata_q};
  assign tcm_cmd_wmask = hi_sel ? {wstrb_q, {(STRB_W/2){1'b0}}}
                                : {{(STRB_W/2){1'b0}}, wstrb_q};
  assign tcm_rsp_ready = (state_q == RD_RSP) || (state_q == WR_RSP);

  // FSM next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (s_axi_arready) begin
          state_d = RD_CMD;
        end else if (s_axi_awready) begin
          state_d = WR_CMD;
        end
      end
      RD_CMD: if (tcm_cmd_ready) state_d = RD_RSP;
      WR_CMD: if (tcm_cmd_ready) state_d = WR_RSP;
      RD_RSP, WR_RSP: if (tcm_rsp_valid) state_d = SEND;
      SEND: begin
        if ((s_axi_rvalid && s_axi_rready) || (s_axi_bvalid && s_axi_bready)) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= IDLE;
      wr_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (s_axi_arready) begin
        wr_q <= 1'b0;
      end else if (s_axi_awready) begin
        wr_q <= 1'b1;
      end
    end
  end

  // Transfer payload
  always_ff @(posedge clk) begin
    if (s_axi_arready) begin
      addr_q <= s_axi_araddr;
    end else if (s_axi_awready) begin
      addr_q  <= s_axi_awaddr;
      wdata_q <= s_axi_wdata;
      wstrb_q <= s_axi_wstrb;
    end
    if (tcm_rsp_valid && tcm_rsp_ready) begin
      rdata_q <= hi_sel ? tcm_rsp_rdata[DATA_W-1:AXI_DATA_W]
                        : tcm_rsp_rdata[AXI_DATA_W-1:0];
      resp_q  <= tcm_rsp_err ? SLVERR : OKAY;
    end
  end

endmodule

`default_nettype wire

//--- hw/dtcm.sv
// DTCM with eight byte lanes, range check and registered response
`timescale 1ns/1ps
`default_nettype none

module dtcm
  import tcm_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic              cmd_read,
  input  logic [DATA_W-1:0] cmd_wdata,
  input  logic [STRB_W-1:0] cmd_wmask,
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output logic [DATA_W-1:0] rsp_rdata,
  output logic              rsp_err
);

  logic              accept;
  logic              in_range;
  logic [RAM_AW-1:0] ram_addr;
  logic [STRB_W-1:0] lane_en;
  logic [DATA_W-1:0] lane_rdata;
  logic              zero_q;

  // Stall only while a response is stuck behind rsp_ready
  assign cmd_ready = !rsp_valid || rsp_ready;
  assign accept    = cmd_valid && cmd_ready;

  // Anything above bit 15 falls outside the 64 KiB array
  assign in_range  = (cmd_addr[ADDR_W-1:$clog2(TCM_BYTES)] == '0);
  assign ram_addr  = cmd_addr[$clog2(STRB_W) +: RAM_AW];

  // ----------------------------------------------------------------------
  // Byte lanes
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < STRB_W; i++) begin : g_lane
    // Reads enable every lane, writes only the masked ones
    assign lane_en[i] = accept && in_range && (cmd_read || cmd_wmask[i]);

    ram_sp i_ram_sp (
      .clk        (clk),
      .addr       (ram_addr),
      .chip_en    (lane_en[i]),
      .write_en   (!cmd_read),
      .write_data (cmd_wdata[8*i +: 8]),
      .read_data  (lane_rdata[8*i +: 8])
    );
  end

  // ----------------------------------------------------------------------
  // Response register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rsp_valid <= 1'b0;
      rsp_err   <= 1'b0;
      zero_q    <= 1'b0;
    end else if (accept) begin
      rsp_valid <= 1'b1;
      rsp_err   <= !in_range;
      zero_q    <= !in_range || !cmd_read;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // Writes and bad addresses return zero
  assign rsp_rdata = zero_q ? '0 : lane_rdata;

endmodule

`default_nettype wire

//--- hw/ram_sp.sv
// Byte-wide single-port synchronous RAM lane with registered read data
`timescale 1ns/1ps
`default_nettype none

module ram_sp
  import tcm_pkg::*;
(
  input  logic              clk,
  input  logic [RAM_AW-1:0] addr,
  input  logic              chip_en,
  input  logic              write_en,
  input  logic [7:0]        write_data,
  output logic [7:0]        read_data
);

  logic [7:0] mem [RAM_DEPTH];

  // ----------------------------------------------------------------------
  // Storage array
  // ----------------------------------------------------------------------
  // Write and read share the single port, write has priority
  always_ff @(posedge clk) begin
    if (chip_en && write_en) begin
      mem[addr] <= write_data;
    end
  end

  // Read data only moves on an enabled read cycle
  always_ff @(posedge clk) begin
    if (chip_en && !write_en) begin
      read_data <= mem[addr];
    end
  end

endmodule

`default_nettype wire

//--- hw/tcm_arbiter.sv
// Round-robin arbiter sharing the DTCM between the LSU and bus ports
`timescale 1ns/1ps
`default_nettype none

module tcm_arbiter
  import tcm_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  // LSU slave port
  input  logic              lsu_cmd_valid,
  output logic              lsu_cmd_ready,
  input  logic [ADDR_W-1:0] lsu_cmd_addr,
  input  logic              lsu_cmd_read,
  input  logic [DATA_W-1:0] lsu_cmd_wdata,
  input  logic [STRB_W-1:0] lsu_cmd_wmask,
  output logic              lsu_rsp_valid,
  input  logic              lsu_rsp_ready,
  output logic [DATA_W-1:0] lsu_rsp_rdata,
  output logic              lsu_rsp_err,
  // Bus bridge slave port
  input  logic              bus_cmd_valid,
  output logic              bus_cmd_ready,
  input  logic [ADDR_W-1:0] bus_cmd_addr,
  input  logic              bus_cmd_read,
  input  logic [DATA_W-1:0] bus_cmd_wdata,
  input  logic [STRB_W-1:0] bus_cmd_wmask,
  output logic              bus_rsp_valid,
  input  logic              bus_rsp_ready,
  output logic [DATA_W-1:0] bus_rsp_rdata,
  output logic              bus_rsp_err,
  // Memory master port
  output logic              mem_cmd_valid,
  input  logic              mem_cmd_ready,
  output logic [ADDR_W-1:0] mem_cmd_addr,
  output logic              mem_cmd_read,
  output logic [DATA_W-1:0] mem_cmd_wdata,
  output logic [STRB_W-1:0] mem_cmd_wmask,
  input  logic              mem_rsp_valid,
  output logic              mem_rsp_ready,
  input  logic [DATA_W-1:0] mem_rsp_rdata,
  input  logic              mem_rsp_err
);

  logic grant_bus;
  logic last_bus_q;
  logic hold_q;
  logic hold_bus_q;
  logic owner_bus_q;
  logic accept;

  // ----------------------------------------------------------------------
  // Command grant
  // ----------------------------------------------------------------------
  // A stalled grant is kept so the memory sees a stable command
  always_comb begin
    if (hold_q) begin
      grant_bus = hold_bus_q;
    end else begin
      grant_bus = bus_cmd_valid && (!lsu_cmd_valid || !last_bus_q);
    end
  end

  assign mem_cmd_valid = lsu_cmd_valid || bus_cmd_valid;
  assign mem_cmd_addr  = grant_bus ? bus_cmd_addr  : lsu_cmd_addr;
  assign mem_cmd_read  = grant_bus ? bus_cmd_read  : lsu_cmd_read;
  assign mem_cmd_wdata = grant_bus ? bus_cmd_wdata : lsu_cmd_wdata;
  assign mem_cmd_wmask = grant_bus ? bus_cmd_wmask : lsu_cmd_wmask;

  assign lsu_cmd_ready = mem_cmd_ready && !grant_bus;
  assign bus_cmd_ready = mem_cmd_ready && grant_bus;
  assign accept        = mem_cmd_valid && mem_cmd_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      last_bus_q  <= 1'b0;
      hold_q      <= 1'b0;
      hold_bus_q  <= 1'b0;
      owner_bus_q <= 1'b0;
    end else begin
      hold_q     <= mem_cmd_valid && !mem_cmd_ready;
      hold_bus_q <= grant_bus;
      if (accept) begin
        last_bus_q  <= grant_bus;
        owner_bus_q <= grant_bus;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Response routing
  // ----------------------------------------------------------------------
  assign lsu_rsp_valid = mem_rsp_valid && !owner_bus_q;
  assign bus_rsp_valid = mem_rsp_valid && owner_bus_q;
  assign mem_rsp_ready = owner_bus_q ? bus_rsp_ready : lsu_rsp_ready;

  assign lsu_rsp_rdata = mem_rsp_rdata;
  assign lsu_rsp_err   = mem_rsp_err;
  assign bus_rsp_rdata = mem_rsp_rdata;
  assign bus_rsp_err   = mem_rsp_err;

endmodule

`default_nettype wire

//--- hw/tcm_pkg.sv
// Memory geometry, bus widths and shared enums for the TCM subsystem
`default_nettype none

package tcm_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 64;
  localparam int STRB_W     = DATA_W / 8;
  localparam int AXI_DATA_W = 32;

  // ----------------------------------------------------------------------
  // Memory geometry
  // ----------------------------------------------------------------------
  // 64 KiB split over eight byte lanes
  localparam int TCM_BYTES  = 65536;
  localparam int RAM_DEPTH  = TCM_BYTES / STRB_W;
  localparam int RAM_AW     = $clog2(RAM_DEPTH);

  // AXI4-Lite response codes, EXOKAY and DECERR are never produced
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

  // Bridge FSM
  typedef enum logic [2:0] {
    IDLE,
    RD_CMD,
    RD_RSP,
    WR_CMD,
    WR_RSP,
    SEND
  } bridge_state_t;

endpackage

`default_nettype wire

//--- hw/tcm_subsys.sv
// DTCM subsystem top with LSU port, AXI4-Lite bridge and arbiter
`timescale 1ns/1ps
`default_nettype none

module tcm_subsys
  import tcm_pkg::*;
(
  input  logic                    clk,
  input  logic                    rstn,
  // LSU port
  input  logic                    lsu_cmd_valid,
  output logic                    lsu_cmd_ready,
  input  logic [ADDR_W-1:0]       lsu_cmd_addr,
  input  logic                    lsu_cmd_read,
  input  logic [DATA_W-1:0]       lsu_cmd_wdata,
  input  logic [STRB_W-1:0]       lsu_cmd_wmask,
  output logic                    lsu_rsp_valid,
  input  logic                    lsu_rsp_ready,
  output logic [DATA_W-1:0]       lsu_rsp_rdata,
  output logic                    lsu_rsp_err,
  // AXI4-Lite slave
  input  logic [ADDR_W-1:0]       s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  logic [AXI_DATA_W-1:0]   s_axi_wdata,
  input  logic [AXI_DATA_W/8-1:0] s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output axi_resp_t               s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  input  logic [ADDR_W-1:0]       s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output logic [AXI_DATA_W-1:0]   s_axi_rdata,
  output axi_resp_t               s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready
);

  // Bridge to arbiter
  logic              bus_cmd_valid;
  logic              bus_cmd_ready;
  logic [ADDR_W-1:0] bus_cmd_addr;
  logic              bus_cmd_read;
  logic [DATA_W-1:0] bus_cmd_wdata;
  logic [STRB_W-1:0] bus_cmd_wmask;
  logic              bus_rsp_valid;
  logic              bus_rsp_ready;
  logic [DATA_W-1:0] bus_rsp_rdata;
  logic              bus_rsp_err;

  // Arbiter to DTCM
  logic              mem_cmd_valid;
  logic              mem_cmd_ready;
  logic [ADDR_W-1:0] mem_cmd_addr;
  logic              mem_cmd_read;
  logic [DATA_W-1:0] mem_cmd_wdata;
  logic [STRB_W-1:0] mem_cmd_wmask;
  logic              mem_rsp_valid;
  logic              mem_rsp_ready;
  logic [DATA_W-1:0] mem_rsp_rdata;
  logic              mem_rsp_err;

  axil_tcm_bridge i_bridge (
    .clk           (clk),
    .rstn          (rstn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .tcm_cmd_valid (bus_cmd_valid),
    .tcm_cmd_ready (bus_cmd_ready),
    .tcm_cmd_addr  (bus_cmd_addr),
    .tcm_cmd_read  (bus_cmd_read),
    .tcm_cmd_wdata (bus_cmd_wdata),
    .tcm_cmd_wmask (bus_cmd_wmask),
    .tcm_rsp_valid (bus_rsp_valid),
    .tcm_rsp_ready (bus_rsp_ready),
    .tcm_rsp_rdata (bus_rsp_rdata),
    .tcm_rsp_err   (bus_rsp_err)
  );

  tcm_arbiter i_arbiter (
    .clk           (clk),
    .rstn          (rstn),
    .lsu_cmd_valid (lsu_cmd_valid),
    .lsu_cmd_ready (lsu_cmd_ready),
    .lsu_cmd_addr  (lsu_cmd_addr),
    .lsu_cmd_read  (lsu_cmd_read),
    .lsu_cmd_wdata (lsu_cmd_wdata),
    .lsu_cmd_wmask (lsu_cmd_wmask),
    .lsu_rsp_valid (lsu_rsp_valid),
    .lsu_rsp_ready (lsu_rsp_ready),
    .lsu_rsp_rdata (lsu_rsp_rdata),
    .lsu_rsp_err   (lsu_rsp_err),
    .bus_cmd_valid (bus_cmd_valid),
    .bus_cmd_ready (bus_cmd_ready),
    .bus_cmd_addr  (bus_cmd_addr),
    .bus_cmd_read  (bus_cmd_read),
    .bus_cmd_wdata (bus_cmd_wdata),
    .bus_cmd_wmask (bus_cmd_wmask),
    .bus_rsp_valid (bus_rsp_valid),
    .bus_rsp_ready (bus_rsp_ready),
    .bus_rsp_rdata (bus_rsp_rdata),
    .bus_rsp_err   (bus_rsp_err),
    .mem_cmd_valid (mem_cmd_valid),
    .mem_cmd_ready (mem_cmd_ready),
    .mem_cmd_addr  (mem_cmd_addr),
    .mem_cmd_read  (mem_cmd_read),
    .mem_cmd_wdata (mem_cmd_wdata),
    .mem_cmd_wmask (mem_cmd_wmask),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_ready (mem_rsp_ready),
    .mem_rsp_rdata (mem_rsp_rdata),
    .mem_rsp_err   (mem_rsp_err)
  );

  dtcm i_dtcm (
    .clk       (clk),
    .rstn      (rstn),
    .cmd_valid (mem_cmd_valid),
    .cmd_ready (mem_cmd_ready),
    .cmd_addr  (mem_cmd_addr),
    .cmd_read  (mem_cmd_read),
    .cmd_wdata (mem_cmd_wdata),
    .cmd_wmask (mem_cmd_wmask),
    .rsp_valid (mem_rsp_valid),
    .rsp_ready (mem_rsp_ready),
    .rsp_rdata (mem_rsp_rdata),
    .rsp_err   (mem_rsp_err)
  );

endmodule

`default_nettype wire

//--- project.f
hw/tcm_pkg.sv
hw/ram_sp.sv
hw/dtcm.sv
hw/tcm_arbiter.sv
hw/axil_tcm_bridge.sv
hw/tcm_subsys.sv
dv/tcm_subsys_asserts.sv
dv/tb_tcm_subsys.sv
